/* logic/sl_defs.svh */
//////////////////////////////////////////////////
// scanline emulation global defines
// colour width, pipeline depth and band offsets
//////////////////////////////////////////////////

`ifndef SL_DEFS_SVH
`define SL_DEFS_SVH

// bits per colour channel
`define SL_COLOR_W 8

// input to output pipeline depth in VCLK cycles
`define SL_LATENCY 9

// band offsets as fraction of a doubled line (8'h80 is half a line)
`define SL_OFF_NORM  8'h40 // 0.25, normal scanline
`define SL_OFF_THICK 8'h20 // 0.125, thick scanline

`endif

/* logic/sl_cfg_pkg.sv */
//////////////////////////////////////////////////
// scanline configuration types
// profile selection and strength word
//////////////////////////////////////////////////

package sl_cfg_pkg;

  // scanline edge profile
  // both linear codes behave the same here
  typedef enum logic [1:0] {
    PROF_SMOOTH   = 2'b00, // soft raised edge
    PROF_LINEAR_A = 2'b01,
    PROF_LINEAR_B = 2'b10,
    PROF_FLAT     = 2'b11  // hard edge at half band
  } sl_profile_e;

  // unsigned fraction, 8'hff is just below 1.0
  typedef logic [7:0] sl_str_t;

  // used for strength, shaped fraction
  // and the bloomed scale factor alike

endpackage

/* logic/vid_pkg.sv */
//////////////////////////////////////////////////
// video payload types
// pixel colour bundle and sync/de bundle
//////////////////////////////////////////////////

`include "sl_defs.svh"

package vid_pkg;

  ////////////////////////////////////////////////
  // pixel

  typedef struct packed {
    logic [`SL_COLOR_W-1:0] r; // red sits in the msbs
    logic [`SL_COLOR_W-1:0] g;
    logic [`SL_COLOR_W-1:0] b;
  } rgb_t;

  ////////////////////////////////////////////////
  // timing signals, travel alongside the pixel

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;    // active pixel
  } sync_t;

endpackage

/* logic/sl_ctrl.sv */
//////////////////////////////////////////////////
// scanline control
// folds line position, evaluates profile and
// delivers draw flag plus corrected strength
//////////////////////////////////////////////////

`include "sl_defs.svh"
`timescale 1ns/1ps

module sl_ctrl (
  input  logic                    VCLK_i,
  input  logic                    nVRST_i,
  input  logic                    sl_en_i,
  input  logic                    sl_thickness_i,
  input  sl_cfg_pkg::sl_profile_e sl_profile_i,
  input  sl_cfg_pkg::sl_str_t     sl_strength_i,
  input  logic [7:0]              sl_rel_pos_i,
  output logic                    draw_o,
  output sl_cfg_pkg::sl_str_t     str_o
);

  localparam logic [7:0] PROF_W = 8'h40; // width of the soft edge region

  logic [7:0]  off_w;       // band offset for current thickness
  logic        flat_w;      // flat top profile selected
  logic [13:0] smooth_w;    // t*(128-t)
  logic [15:0] str_full_w;  // shape * strength

  logic [7:0]  fold_q;      // stage 1
  logic [7:0]  diff_q;      // stage 2
  logic        draw1_q, sat1_q;
  logic [7:0]  shape_q;     // stage 3
  logic        draw2_q, sat2_q;

  assign off_w  = sl_thickness_i ? `SL_OFF_THICK : `SL_OFF_NORM;
  assign flat_w = (sl_profile_i == sl_cfg_pkg::PROF_FLAT);

  // t = diff[5:0], max is 63*65 = 4095 so [11:4] holds the full result
  assign smooth_w   = diff_q[5:0] * (8'd128 - {2'b00, diff_q[5:0]});
  assign str_full_w = shape_q * sl_strength_i;

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      fold_q  <= 8'h00;
      diff_q  <= 8'h00;
      draw1_q <= 1'b0;
      sat1_q  <= 1'b0;
      shape_q <= 8'h00;
      draw2_q <= 1'b0;
      sat2_q  <= 1'b0;
      draw_o  <= 1'b0;
      str_o   <= 8'h00;
    end else begin
      // stage 1, mirror lower half so the centre distance runs 0..0x80
      fold_q <= (sl_rel_pos_i > 8'h80) ? 8'h00 - sl_rel_pos_i : sl_rel_pos_i;

      // stage 2
      diff_q  <= fold_q - off_w;              // wraps below the band
      draw1_q <= fold_q > off_w;              // inside band
      sat1_q  <= fold_q >= off_w + PROF_W;    // past soft edge, full strength

      // stage 3
      draw2_q <= flat_w ? diff_q[5] : draw1_q; // flat top switches at half edge
      sat2_q  <= flat_w ? diff_q[5] : sat1_q;
      case (sl_profile_i)
        sl_cfg_pkg::PROF_SMOOTH: shape_q <= smooth_w[11:4];
        default:                 shape_q <= {diff_q[5:0], diff_q[5:4]}; // t*4 + t/16
      endcase

      // stage 4
      draw_o <= sl_en_i & draw2_q;
      str_o  <= sat2_q ? sl_strength_i : str_full_w[15:8];
    end
  end

endmodule

/* logic/sl_luma.sv */
//////////////////////////////////////////////////
// luma approximation and bloom pre-scale
//////////////////////////////////////////////////

`include "sl_defs.svh"
`timescale 1ns/1ps

module sl_luma (
  input  logic                 VCLK_i,
  input  logic                 nVRST_i,
  input  vid_pkg::rgb_t        rgb_i,
  input  logic [4:0]           sl_bloom_i,
  output logic [`SL_COLOR_W:0] yref_pre_o
);

  logic [`SL_COLOR_W:0]   rpb_q;       // r + b, stage 1
  logic [`SL_COLOR_W-1:0] g_q;         // green aligned to rpb
  logic [`SL_COLOR_W:0]   ysum_w;      // g + (r+b)/2
  logic [`SL_COLOR_W-1:0] y_q;         // luma, stage 2
  logic [`SL_COLOR_W+4:0] ypre_full_w; // luma * bloom
  logic [`SL_COLOR_W:0]   ypre_q;      // stage 3

  assign ysum_w      = {1'b0, g_q} + {1'b0, rpb_q[`SL_COLOR_W:1]};
  assign ypre_full_w = y_q * sl_bloom_i;

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      rpb_q      <= '0;
      g_q        <= '0;
      y_q        <= '0;
      ypre_q     <= '0;
      yref_pre_o <= '0;
    end else begin
      rpb_q      <= {1'b0, rgb_i.r} + {1'b0, rgb_i.b};
      g_q        <= rgb_i.g;
      y_q        <= ysum_w[`SL_COLOR_W:1];                   // halve the sum
      ypre_q     <= {1'b0, ypre_full_w[`SL_COLOR_W+4:5]};    // bloom is x/32
      yref_pre_o <= ypre_q;                                  // align with ctrl
    end
  end

endmodule

/* logic/sl_delay.sv */
//////////////////////////////////////////////////
// pipeline alignment delay
// shift register for any packed payload
//////////////////////////////////////////////////

`timescale 1ns/1ps

module sl_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1     // number of register stages
) (
  input  logic     VCLK_i,
  input  logic     nVRST_i,
  input  payload_t data_i,
  output payload_t data_o
);

  payload_t dly_q [DEPTH]; // [0] is the newest sample

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        dly_q[i] <= '0;
      end
    end else begin
      dly_q[0] <= data_i;
      for (int i = 1; i < DEPTH; i++) begin
        dly_q[i] <= dly_q[i-1];
      end
    end
  end

  assign data_o = dly_q[DEPTH-1];

endmodule

/* logic/sl_mix.sv */
//////////////////////////////////////////////////
// scanline mixer
// bloom adaptation, colour scaling and the
// registered output selection
//////////////////////////////////////////////////

`include "sl_defs.svh"
`timescale 1ns/1ps

module sl_mix (
  input  logic                 VCLK_i,
  input  logic                 nVRST_i,
  input  logic                 draw_i,     // stage 4
  input  sl_cfg_pkg::sl_str_t  str_i,      // stage 4
  input  logic [`SL_COLOR_W:0] yref_pre_i, // stage 4
  input  vid_pkg::rgb_t        rgb_dly_i,  // stage 7
  input  vid_pkg::rgb_t        rgb_byp_i,  // stage 8
  input  vid_pkg::sync_t       sync_i,     // stage 8
  output logic                 HSYNC_o,
  output logic                 VSYNC_o,
  output logic                 DE_o,
  output vid_pkg::rgb_t        vdata_o
);

  logic [`SL_COLOR_W+8:0] yref_full_w;              // pre-ref * strength
  logic [`SL_COLOR_W+7:0] r_full_w, g_full_w, b_full_w;

  logic [`SL_COLOR_W:0]   yref_q;  // stage 5
  sl_cfg_pkg::sl_str_t    str5_q;
  sl_cfg_pkg::sl_str_t    rval_q;  // stage 6, bloom reduced strength
  sl_cfg_pkg::sl_str_t    k_q;     // stage 7, colour gain
  vid_pkg::rgb_t          rgb_sl_q; // stage 8, darkened pixel
  logic [8:5]             draw_q;   // draw flag per stage

  assign yref_full_w = yref_pre_i * str_i;
  assign r_full_w    = rgb_dly_i.r * k_q;
  assign g_full_w    = rgb_dly_i.g * k_q;
  assign b_full_w    = rgb_dly_i.b * k_q;

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      yref_q   <= '0;
      str5_q   <= 8'h00;
      rval_q   <= 8'h00;
      k_q      <= 8'h00;
      rgb_sl_q <= '0;
      draw_q   <= '0;
      HSYNC_o  <= 1'b0;
      VSYNC_o  <= 1'b0;
      DE_o     <= 1'b0;
      vdata_o  <= '0;
    end else begin
      ////////////////////////////////////////////////
      // bloom adaptation

      yref_q <= yref_full_w[`SL_COLOR_W+8:8];   // stage 5
      str5_q <= str_i;
      rval_q <= ({1'b0, str5_q} > yref_q) ? str5_q - yref_q[7:0] : 8'h00; // floor at 0
      k_q    <= 8'hff - rval_q;                 // stage 7

      ////////////////////////////////////////////////
      // colour scaling

      rgb_sl_q.r <= r_full_w[`SL_COLOR_W+7:8]; // stage 8
      rgb_sl_q.g <= g_full_w[`SL_COLOR_W+7:8];
      rgb_sl_q.b <= b_full_w[`SL_COLOR_W+7:8];
      draw_q     <= {draw_q[7:5], draw_i};

      ////////////////////////////////////////////////
      // output stage 9

      HSYNC_o <= sync_i.hsync;
      VSYNC_o <= sync_i.vsync;
      DE_o    <= sync_i.de;
      // blanking is never darkened
      vdata_o <= (sync_i.de && draw_q[8]) ? rgb_sl_q : rgb_byp_i;
    end
  end

endmodule

/* logic/scanline_top.sv */
//////////////////////////////////////////////////
// scanline emulation top level
// control, luma and mixer with alignment delays
//////////////////////////////////////////////////

`include "sl_defs.svh"
`timescale 1ns/1ps

module scanline_top (
  input  logic                    VCLK_i,
  input  logic                    nVRST_i,
  input  logic                    HSYNC_i,
  input  logic                    VSYNC_i,
  input  logic                    DE_i,
  input  vid_pkg::rgb_t           vdata_i,
  input  logic [7:0]              sl_rel_pos_i,  // position inside doubled line
  input  logic                    sl_en_i,
  input  logic                    sl_thickness_i,
  input  sl_cfg_pkg::sl_profile_e sl_profile_i,
  input  sl_cfg_pkg::sl_str_t     sl_strength_i,
  input  logic [4:0]              sl_bloom_i,
  output logic                    HSYNC_o,
  output logic                    VSYNC_o,
  output logic                    DE_o,
  output vid_pkg::rgb_t           vdata_o
);

  logic                 draw_w;
  sl_cfg_pkg::sl_str_t  str_w;
  logic [`SL_COLOR_W:0] yref_pre_w;
  vid_pkg::rgb_t        rgb_dly_w;   // feeds the multipliers
  vid_pkg::rgb_t        rgb_byp_w;   // unscaled pixel for the output mux
  vid_pkg::sync_t       sync_in_w, sync_dly_w;

  assign sync_in_w = '{hsync: HSYNC_i, vsync: VSYNC_i, de: DE_i};

  sl_ctrl u_ctrl (
    .VCLK_i, .nVRST_i,
    .sl_en_i, .sl_thickness_i, .sl_profile_i, .sl_strength_i, .sl_rel_pos_i,
    .draw_o (draw_w),
    .str_o  (str_w)
  );

  sl_luma u_luma (
    .VCLK_i, .nVRST_i,
    .rgb_i      (vdata_i),
    .sl_bloom_i,
    .yref_pre_o (yref_pre_w)
  );

  // scaler input one stage ahead of the bypass copy
  sl_delay #(.payload_t(vid_pkg::rgb_t), .DEPTH(`SL_LATENCY-2)) u_rgb_dly (
    .VCLK_i, .nVRST_i, .data_i (vdata_i), .data_o (rgb_dly_w)
  );

  sl_delay #(.payload_t(vid_pkg::rgb_t), .DEPTH(`SL_LATENCY-1)) u_rgb_byp (
    .VCLK_i, .nVRST_i, .data_i (vdata_i), .data_o (rgb_byp_w)
  );

  sl_delay #(.payload_t(vid_pkg::sync_t), .DEPTH(`SL_LATENCY-1)) u_sync_dly (
    .VCLK_i, .nVRST_i, .data_i (sync_in_w), .data_o (sync_dly_w)
  );

  sl_mix u_mix (
    .VCLK_i, .nVRST_i,
    .draw_i     (draw_w),
    .str_i      (str_w),
    .yref_pre_i (yref_pre_w),
    .rgb_dly_i  (rgb_dly_w),
    .rgb_byp_i  (rgb_byp_w),
    .sync_i     (sync_dly_w),
    .HSYNC_o, .VSYNC_o, .DE_o, .vdata_o
  );

endmodule

/* dv/scanline_properties.sv */
//////////////////////////////////////////////////
// scanline output checks
// reset values, sync latency, blanking pass-through
//////////////////////////////////////////////////

`include "sl_defs.svh"
`timescale 1ns/1ps

module scanline_properties (
  input logic          VCLK_i,
  input logic          nVRST_i,
  input logic          DE_i,
  input vid_pkg::rgb_t vdata_i,
  input logic          HSYNC_o,
  input logic          VSYNC_o,
  input logic          DE_o,
  input vid_pkg::rgb_t vdata_o
);

  int unsigned fail_cnt = 0; // failed assertion count
  logic [3:0]  fill_q;       // cycles since reset release, stops at latency

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      fill_q <= '0;
    end else if (fill_q < `SL_LATENCY) begin
      fill_q <= fill_q + 1'b1; // pipeline still holds reset values
    end
  end

  rst_zero_a: assert property (@(posedge VCLK_i)
    !nVRST_i |-> (!HSYNC_o && !VSYNC_o && !DE_o && vdata_o == '0))
    else begin fail_cnt++; $error("outputs not zero while reset is active"); end

  de_delay_a: assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    (fill_q == `SL_LATENCY) |-> (DE_o == $past(DE_i, `SL_LATENCY)))
    else begin fail_cnt++; $error("DE_o is not DE_i delayed by pipeline latency"); end

  blank_pass_a: assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    (fill_q == `SL_LATENCY && !DE_o) |-> (vdata_o == $past(vdata_i, `SL_LATENCY)))
    else begin fail_cnt++; $error("blanking pixel was modified"); end

endmodule

/* dv/tb_scanline.sv */
//////////////////////////////////////////////////
// scanline testbench
// lfsr stimulus checked against a reference model
//////////////////////////////////////////////////

`include "sl_defs.svh"
`timescale 1ns/1ps

module tb_scanline;

  typedef struct packed {
    vid_pkg::sync_t s;
    vid_pkg::rgb_t  p;
  } sample_t;

  localparam int N_TESTS  = 8;
  localparam int STIM_CYC = 300 + 2*200 + 2*250 + 250 + 250 + 300; // active samples
  localparam int MAX_CYC  = (STIM_CYC + N_TESTS*12 + 5) * 11 / 10;  // plus idle, reset, 10 %

  logic                    vclk, nvrst;
  logic                    hsync, vsync, de;
  vid_pkg::rgb_t           vdata;
  logic [7:0]              rel_pos;
  logic                    sl_en, sl_thick;
  sl_cfg_pkg::sl_profile_e sl_prof;
  sl_cfg_pkg::sl_str_t     sl_str;
  logic [4:0]              sl_bloom;
  logic                    hsync_out, vsync_out, de_out;
  vid_pkg::rgb_t           vdata_out;

  logic [31:0] lfsr = 32'hf30f;
  sample_t     exp_q[$];      // model results in flight
  int          n_checks = 0;
  int          n_errors = 0;
  int          cyc_cnt  = 0;

  scanline_top i_scanline_top (
    .VCLK_i (vclk), .nVRST_i (nvrst),
    .HSYNC_i (hsync), .VSYNC_i (vsync), .DE_i (de), .vdata_i (vdata),
    .sl_rel_pos_i (rel_pos), .sl_en_i (sl_en), .sl_thickness_i (sl_thick),
    .sl_profile_i (sl_prof), .sl_strength_i (sl_str), .sl_bloom_i (sl_bloom),
    .HSYNC_o (hsync_out), .VSYNC_o (vsync_out), .DE_o (de_out), .vdata_o (vdata_out)
  );

  bind scanline_top scanline_properties u_props (
    .VCLK_i, .nVRST_i, .DE_i, .vdata_i, .HSYNC_o, .VSYNC_o, .DE_o, .vdata_o
  );

  initial begin
    vclk = 1'b0;
    forever #5 vclk = ~vclk; // 100 MHz
  end

  always @(posedge vclk) begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYC) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYC);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////////////
  // stimulus and model

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
  endfunction

  function automatic vid_pkg::rgb_t model_pixel(input logic [7:0] rel, input vid_pkg::rgb_t c,
                                                input logic de_v);
    int            f, off, d, t, shape, str, y, pre, yref, k;
    logic          draw, sat;
    vid_pkg::rgb_t o;
    f     = (rel > 8'h80) ? 256 - rel : rel;      // distance folded to upper half
    off   = sl_thick ? `SL_OFF_THICK : `SL_OFF_NORM;
    d     = (f - off) & 'hff;
    t     = d & 'h3f;
    draw  = f > off;
    sat   = f >= off + 'h40;
    if (sl_prof == sl_cfg_pkg::PROF_FLAT) begin
      draw = d[5];                                // hard edge
      sat  = d[5];
    end
    shape = (sl_prof == sl_cfg_pkg::PROF_SMOOTH) ? (t * (128 - t)) >> 4 : t * 4 + (t >> 4);
    str   = sat ? sl_str : (shape * sl_str) >> 8;
    y     = (c.g + ((c.r + c.b) >> 1)) >> 1;      // cheap luma
    pre   = (y * sl_bloom) >> 5;
    yref  = (pre * str) >> 8;
    k     = 255 - ((str > yref) ? str - yref : 0);
    o     = c;                                    // untouched unless darkened
    if (sl_en && draw && de_v) begin
      o.r = 8'((c.r * k) >> 8);
      o.g = 8'((c.g * k) >> 8);
      o.b = 8'((c.b * k) >> 8);
    end
    return o;
  endfunction

  task automatic check_value(input string sig, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("MISMATCH t=%0t %s expected 'h%0h actual 'h%0h", $time, sig, exp_v, act_v);
    end
  endtask

  // one pixel per falling edge, oldest result checked first
  task automatic drive_sample(input logic de_v);
    sample_t e;
    @(negedge vclk);
    if (exp_q.size() == `SL_LATENCY) begin
      e = exp_q.pop_front();
      check_value("HSYNC_o", e.s.hsync, hsync_out);
      check_value("VSYNC_o", e.s.vsync, vsync_out);
      check_value("DE_o", e.s.de, de_out);
      check_value("vdata_o", e.p, vdata_out);
    end
    {hsync, vsync} = 2'(rand_bits(2));
    de      = de_v;
    rel_pos = 8'(rand_bits(8));
    vdata   = 24'(rand_bits(24));
    e.s     = {hsync, vsync, de};
    e.p     = model_pixel(rel_pos, vdata, de);
    exp_q.push_back(e);
  endtask

  // config only changes here, after the previous test drained
  task automatic run_test(input string name, input int n, input logic en, input logic thick,
                          input sl_cfg_pkg::sl_profile_e prof, input logic [7:0] str,
                          input logic [4:0] bloom, input logic rand_de);
    int err0;
    err0     = n_errors;
    sl_en    = en;
    sl_thick = thick;
    sl_prof  = prof;
    sl_str   = str;
    sl_bloom = bloom;
    for (int i = 0; i < n; i++) begin
      drive_sample(rand_de ? 1'(rand_bits(1)) : 1'b1);
    end
    repeat (12) drive_sample(1'b0); // blanking flushes the pipeline
    $display("test %s: %0d samples, %0d errors", name, n, n_errors - err0);
  endtask

  ////////////////////////////////////////////////
  // test sequence

  initial begin
    nvrst    = 1'b1;
    hsync    = 1'b0;
    vsync    = 1'b0;
    de       = 1'b0;
    vdata    = '0;
    rel_pos  = 8'h00;
    sl_en    = 1'b0;
    sl_thick = 1'b0;
    sl_prof  = sl_cfg_pkg::PROF_SMOOTH;
    sl_str   = 8'h00;
    sl_bloom = 5'd0;
    #1 nvrst = 1'b0; // reset asserted before the first rising edge
    repeat (5) @(negedge vclk);
    nvrst = 1'b1;
    run_test("pass-through", 300, 1'b0, 1'b0, sl_cfg_pkg::PROF_SMOOTH, 8'h80, 5'd16, 1'b1);
    run_test("linear normal", 200, 1'b1, 1'b0, sl_cfg_pkg::PROF_LINEAR_A, 8'h00, 5'd0, 1'b0);
    run_test("linear thick", 200, 1'b1, 1'b1, sl_cfg_pkg::PROF_LINEAR_B, 8'h00, 5'd0, 1'b0);
    run_test("smooth normal", 250, 1'b1, 1'b0, sl_cfg_pkg::PROF_SMOOTH, 8'(rand_bits(8)),
             5'd0, 1'b0);
    run_test("smooth thick", 250, 1'b1, 1'b1, sl_cfg_pkg::PROF_SMOOTH, 8'(rand_bits(8)),
             5'd0, 1'b0);
    run_test("flat top", 250, 1'b1, 1'(rand_bits(1)), sl_cfg_pkg::PROF_FLAT,
             8'(rand_bits(8)), 5'd0, 1'b0);
    run_test("bloom", 250, 1'b1, 1'b0, sl_cfg_pkg::PROF_SMOOTH, 8'hff,
             5'(rand_bits(5)) | 5'h10, 1'b0);   // strong bloom
    run_test("blanking", 300, 1'b1, 1'b0, sl_cfg_pkg::PROF_LINEAR_A, 8'(rand_bits(8)),
             5'(rand_bits(5)), 1'b1);
    $display("summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
             N_TESTS, n_checks, n_errors, i_scanline_top.u_props.fail_cnt);
    if (n_errors == 0 && i_scanline_top.u_props.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+logic
logic/sl_cfg_pkg.sv
logic/vid_pkg.sv
logic/sl_ctrl.sv
logic/sl_luma.sv
logic/sl_delay.sv
logic/sl_mix.sv
logic/scanline_top.sv
dv/scanline_properties.sv
dv/tb_scanline.sv

/* Bender.yml */
package:
  name: scanline

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/sl_cfg_pkg.sv
      - logic/vid_pkg.sv
      - logic/sl_ctrl.sv
      - logic/sl_luma.sv
      - logic/sl_delay.sv
      - logic/sl_mix.sv
      - logic/scanline_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/scanline_properties.sv
      - dv/tb_scanline.sv
